//--- detTop.f
verilog/detPkg.sv
verilog/exactDivider.sv
verilog/matrixRam.sv
verilog/matrixLoader.sv
verilog/bareissEngine.sv
verilog/detTop.sv
testbench/memModel.sv
testbench/detTopTb.sv

//--- testbench/detTopTb.sv
// Testbench for the determinant unit; directed tests against a cofactor-expansion reference
module detTopTb
    import detPkg::*;
();
    localparam int Limit = 10000;  // cycles allowed per wait
    localparam int unsigned Seed = 32'h5ae4_8f70;

    logic                    clk;
    logic                    rstN;
    logic                    cmdReq;
    logic [AddrW-1:0]        cmdBase;
    logic [DimW-1:0]         cmdDim;
    logic                    cmdAck;
    logic                    resultReq;
    logic                    resultAck;
    logic signed [ElemW-1:0] detValue;
    detStatusT               detStatus;
    logic [AddrW-1:0]        memAddress;
    logic                    memRead;
    logic                    memWaitRequest;
    logic [DataW-1:0]        memReadData;
    logic                    memReadDataValid;
    longint                  mat [16];  // row r at r * 4 as in the RAM
    int                      errors;
    int                      tests;
    int                      readCycles;
    int                      i;
    bit                      holdCheck;
    int unsigned             seedVal;

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (memRead) readCycles++;
    end

    // back-pressure watch while an older result is pending
    always @(negedge clk) begin
        if (holdCheck && cmdAck) begin
            $display("cmdAck rose before the previous result handshake had finished");
            errors++;
        end
    end

    detTop detTop_i (
        .clk(clk), .rstN(rstN), .cmdReq(cmdReq), .cmdBase(cmdBase), .cmdDim(cmdDim),
        .cmdAck(cmdAck), .resultReq(resultReq), .resultAck(resultAck), .detValue(detValue),
        .detStatus(detStatus), .memAddress(memAddress), .memRead(memRead),
        .memWaitRequest(memWaitRequest), .memReadData(memReadData),
        .memReadDataValid(memReadDataValid)
    );

    memModel memModel_i (
        .clk(clk), .rstN(rstN), .memAddress(memAddress), .memRead(memRead),
        .memWaitRequest(memWaitRequest), .memReadData(memReadData),
        .memReadDataValid(memReadDataValid)
    );

    task automatic abortRun(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TESTS FAILED");
        $finish;
    endtask

    function automatic longint entryAt(input int r, input int c);
        return mat[r * 4 + c];
    endfunction

    // 3 x 3 determinant of the chosen rows and columns of mat
    function automatic longint det3(input int r0, input int r1, input int r2,
                                    input int c0, input int c1, input int c2);
        longint t0;
        longint t1;
        longint t2;
        t0 = entryAt(r1, c1) * entryAt(r2, c2) - entryAt(r1, c2) * entryAt(r2, c1);
        t1 = entryAt(r1, c0) * entryAt(r2, c2) - entryAt(r1, c2) * entryAt(r2, c0);
        t2 = entryAt(r1, c0) * entryAt(r2, c1) - entryAt(r1, c1) * entryAt(r2, c0);
        return entryAt(r0, c0) * t0 - entryAt(r0, c1) * t1 + entryAt(r0, c2) * t2;
    endfunction

    // cofactor expansion along row 0 of the leading n x n block
    function automatic longint detOf(input int n);
        longint acc;
        int     c;
        int     c0;
        int     c1;
        int     c2;
        acc = 0;
        if (n == 1) begin
            acc = entryAt(0, 0);
        end else if (n == 2) begin
            acc = entryAt(0, 0) * entryAt(1, 1) - entryAt(0, 1) * entryAt(1, 0);
        end else if (n == 3) begin
            acc = det3(0, 1, 2, 0, 1, 2);
        end else begin
            for (c = 0; c < 4; c++) begin
                c0 = (c == 0) ? 1 : 0;  // columns left after striking c
                c1 = (c <= 1) ? 2 : 1;
                c2 = (c <= 2) ? 3 : 2;
                acc += ((c % 2) ? -entryAt(0, c) : entryAt(0, c)) * det3(1, 2, 3, c0, c1, c2);
            end
        end
        return acc;
    endfunction

    task automatic checkValue(input string sig, input logic signed [ElemW-1:0] got,
                              input logic signed [ElemW-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic checkStatus(input string sig, input detStatusT got, input detStatusT exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic putRow(input int r, input longint a, input longint b,
                          input longint c, input longint d);
        mat[r * 4]     = a;
        mat[r * 4 + 1] = b;
        mat[r * 4 + 2] = c;
        mat[r * 4 + 3] = d;
    endtask

    task automatic fillRandom(input int dim);
        int r;
        int c;
        for (r = 0; r < dim; r++) begin
            for (c = 0; c < dim; c++) begin
                mat[r * 4 + c] = longint'($urandom % 255) - 64'sd127;
            end
        end
    endtask

    // entries packed row after row with junk in the upper bytes
    task automatic storeMatrix(input logic [AddrW-1:0] base, input int dim);
        int r;
        int c;
        if (dim > MaxDim) return;
        for (r = 0; r < dim; r++) begin
            for (c = 0; c < dim; c++) begin
                memModel_i.words[base[9:2] + r * dim + c] = {24'($urandom), 8'(mat[r * 4 + c])};
            end
        end
    endtask

    task automatic raiseCommand(input logic [AddrW-1:0] base, input int dim);
        @(negedge clk);
        cmdBase = base;
        cmdDim  = DimW'(dim);
        cmdReq  = 1'b1;
    endtask

    task automatic finishCommand();
        int n;
        n = 0;
        while (cmdAck !== 1'b1) begin
            if (n == Limit) abortRun("cmdAck to rise");
            @(negedge clk);
            n++;
        end
        cmdReq = 1'b0;
        n = 0;
        while (cmdAck !== 1'b0) begin
            if (n == Limit) abortRun("cmdAck to fall");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic takeResult(output logic signed [ElemW-1:0] val, output detStatusT st);
        int n;
        n = 0;
        while (resultReq !== 1'b1) begin
            if (n == Limit) abortRun("resultReq to rise");
            @(negedge clk);
            n++;
        end
        val       = detValue;
        st        = detStatus;
        resultAck = 1'b1;
        n = 0;
        while (resultReq !== 1'b0) begin
            if (n == Limit) abortRun("resultReq to fall");
            @(negedge clk);
            n++;
        end
        resultAck = 1'b0;
    endtask

    // zero leading minor below full order means a zero pivot
    task automatic expectFor(input int dim, output longint v, output detStatusT st);
        int k;
        v  = 0;
        st = detOk;
        if (dim < MinDim || dim > MaxDim) begin
            st = detBadDim;
            return;
        end
        for (k = 1; k < dim; k++) begin
            if (detOf(k) == 0) st = detPivotZero;
        end
        if (st == detOk) v = detOf(dim);
    endtask

    task automatic checkResult(input string name, input int dim);
        longint                  expV;
        detStatusT               expS;
        logic signed [ElemW-1:0] gotV;
        detStatusT               gotS;
        int                      errBefore;
        errBefore = errors;
        expectFor(dim, expV, expS);
        takeResult(gotV, gotS);
        checkValue("detValue", gotV, expV);
        checkStatus("detStatus", gotS, expS);
        if (expS == detBadDim && readCycles != 0) begin
            $display("memRead was raised for a rejected dimension");
            errors++;
        end
        tests++;
        $display("%s: %s", name, (errors == errBefore) ? "ok" : "errors seen");
    endtask

    task automatic runMatrix(input string name, input logic [AddrW-1:0] base, input int dim);
        storeMatrix(base, dim);
        readCycles = 0;
        raiseCommand(base, dim);
        finishCommand();
        checkResult(name, dim);
    endtask

    // second command waits behind a running one
    task automatic overlapCommands();
        longint saved [16];
        fillRandom(3);
        storeMatrix(24'h300, 3);
        saved = mat;
        fillRandom(3);
        storeMatrix(24'h080, 3);
        raiseCommand(24'h080, 3);
        finishCommand();
        raiseCommand(24'h300, 3);
        holdCheck = 1'b1;
        checkResult("overlap first", 3);
        holdCheck = 1'b0;
        mat = saved;
        finishCommand();
        checkResult("overlap second", 3);
    endtask

    initial begin
        seedVal    = $urandom(Seed);
        clk        = 1'b0;
        rstN       = 1'b0;
        cmdReq     = 1'b0;
        cmdBase    = '0;
        cmdDim     = '0;
        resultAck  = 1'b0;
        errors     = 0;
        tests      = 0;
        readCycles = 0;
        holdCheck  = 1'b0;
        repeat (10) @(negedge clk);
        rstN = 1'b1;

        putRow(0, 3, 8, 0, 0);
        putRow(1, 4, 6, 0, 0);
        runMatrix("known 2x2", 24'h000, 2);
        putRow(0, 2, -3, 1, 0);
        putRow(1, 2, 0, -1, 0);
        putRow(2, 1, 4, 5, 0);
        runMatrix("known 3x3", 24'h040, 3);
        putRow(0, 1, 0, 0, 0);
        putRow(1, 0, 1, 0, 0);
        putRow(2, 0, 0, 1, 0);
        putRow(3, 0, 0, 0, 1);
        runMatrix("identity 4x4", 24'h080, 4);

        for (i = 0; i < 4; i++) begin
            fillRandom(4);
            runMatrix("random 4x4", 24'h100, 4);
            fillRandom(3);
            runMatrix("random 3x3", 24'h180, 3);
        end

        putRow(0, 0, 1, 2, 0);
        putRow(1, 3, 4, 5, 0);
        putRow(2, 6, 7, 9, 0);
        runMatrix("zero first pivot", 24'h000, 3);
        putRow(0, 1, 2, 3, 0);
        putRow(1, 2, 4, 5, 0);  // second leading minor is zero
        putRow(2, 1, 1, 1, 0);
        runMatrix("zero second pivot", 24'h040, 3);

        runMatrix("dimension 1", 24'h000, 1);
        runMatrix("dimension 5", 24'h000, 5);

        overlapCommands();

        fillRandom(4);
        storeMatrix(24'h1c0, 4);  // decoy words just below the base
        fillRandom(4);
        runMatrix("base 0x200", 24'h200, 4);

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/memModel.sv
// Memory model for the testbench; answers pipelined reads in order with random wait-request and latency
module memModel
    import detPkg::*;
(
    input  logic             clk,
    input  logic             rstN,
    input  logic [AddrW-1:0] memAddress,
    input  logic             memRead,
    output logic             memWaitRequest,
    output logic [DataW-1:0] memReadData,
    output logic             memReadDataValid
);
    localparam int Words = 256;

    logic [DataW-1:0] words [Words];  // written by the testbench
    logic [DataW-1:0] dataQ [$];
    int               dueQ [$];
    int               cycle;
    int               due;
    int               idx;

    initial begin
        memWaitRequest   = 1'b0;
        memReadData      = '0;
        memReadDataValid = 1'b0;
        cycle            = 0;
        // odd multiplier keeps every low byte distinct
        for (idx = 0; idx < Words; idx++) begin
            words[idx] = {24'(idx) ^ 24'h5a5a5a, 8'(idx * 37)};
        end
    end

    // accept side
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rstN && memRead && !memWaitRequest) begin
            dataQ.push_back(words[memAddress[9:2]]);
            due = cycle + int'($urandom % 4);  // 0 to 3 extra cycles
            dueQ.push_back(due);
        end
    end

    // return side, one word per cycle in request order
    always @(negedge clk) begin
        memWaitRequest   = ($urandom % 4) == 0;
        memReadDataValid = 1'b0;
        if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
            memReadData      = dataQ.pop_front();
            due              = dueQ.pop_front();
            memReadDataValid = 1'b1;
        end
    end

endmodule

//--- verilog/detTop.sv
// Determinant unit top level; takes a command over req/ack, loads the matrix and returns the result
module detTop
    import detPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    cmdReq,
    input  logic [AddrW-1:0]        cmdBase,
    input  logic [DimW-1:0]         cmdDim,
    output logic                    cmdAck,
    output logic                    resultReq,
    input  logic                    resultAck,
    output logic signed [ElemW-1:0] detValue,
    output detStatusT               detStatus,
    output logic [AddrW-1:0]        memAddress,
    output logic                    memRead,
    input  logic                    memWaitRequest,
    input  logic [DataW-1:0]        memReadData,
    input  logic                    memReadDataValid
);
    topStateT                state;
    logic [AddrW-1:0]        baseR;
    logic [DimW-1:0]         dimR;
    logic                    badDimR;
    logic                    dimBad;
    logic                    accept;
    logic                    loadStart;
    logic                    loadDone;
    logic                    engineStart;
    logic                    engineDone;
    logic signed [ElemW-1:0] engineValue;
    detStatusT               engineStatus;
    logic                    ramWrEn;     // loader side
    logic [RamAddrW-1:0]     ramWrAddr;
    logic signed [ElemW-1:0] ramWrData;
    logic                    ramWrEn2;    // engine side
    logic [RamAddrW-1:0]     ramWrAddr2;
    logic signed [ElemW-1:0] ramWrData2;
    logic                    ramSelEn;
    logic [RamAddrW-1:0]     ramSelAddr;
    logic signed [ElemW-1:0] ramSelData;
    logic [RamAddrW-1:0]     ramRdAddr;
    logic signed [ElemW-1:0] ramRdData;

    assign dimBad = (cmdDim < MinDim) || (cmdDim > MaxDim);
    // new command only once the previous result handshake is fully closed
    assign accept = (state == topIdle) && cmdReq && !cmdAck && !resultAck;

    always_comb begin
        if (state == topLoading) begin
            ramSelEn   = ramWrEn;
            ramSelAddr = ramWrAddr;
            ramSelData = ramWrData;
        end else begin
            ramSelEn   = ramWrEn2 && (state == topComputing);
            ramSelAddr = ramWrAddr2;
            ramSelData = ramWrData2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state       <= topIdle;
            cmdAck      <= 1'b0;
            resultReq   <= 1'b0;
            loadStart   <= 1'b0;
            engineStart <= 1'b0;
        end else begin
            loadStart   <= 1'b0;
            engineStart <= 1'b0;
            if (!cmdReq) cmdAck <= 1'b0;  // release follows the requester
            case (state)
                topIdle: if (accept) begin
                    cmdAck    <= 1'b1;
                    baseR     <= cmdBase;
                    dimR      <= cmdDim;
                    badDimR   <= dimBad;
                    loadStart <= !dimBad;
                    state     <= topLoading;
                end
                topLoading: if (badDimR) begin
                    detValue  <= '0;
                    detStatus <= detBadDim;
                    state     <= topReporting;
                end else if (loadDone) begin
                    engineStart <= 1'b1;
                    state       <= topComputing;
                end
                topComputing: if (engineDone) begin
                    detValue  <= engineValue;
                    detStatus <= engineStatus;
                    state     <= topReporting;
                end
                topReporting: if (!resultReq) begin
                    resultReq <= 1'b1;
                end else if (resultAck) begin
                    resultReq <= 1'b0;
                    state     <= topIdle;
                end
                default: state <= topIdle;
            endcase
        end
    end

    matrixLoader matrixLoader_i (
        .clk(clk), .rstN(rstN), .loadStart(loadStart), .loadBase(baseR), .loadDim(dimR),
        .memAddress(memAddress), .memRead(memRead), .memWaitRequest(memWaitRequest),
        .memReadData(memReadData), .memReadDataValid(memReadDataValid),
        .ramWrEn(ramWrEn), .ramWrAddr(ramWrAddr), .ramWrData(ramWrData), .loadDone(loadDone)
    );

    matrixRam matrixRam_i (
        .clk(clk), .wrEn(ramSelEn), .wrAddr(ramSelAddr), .wrData(ramSelData),
        .rdAddr(ramRdAddr), .rdData(ramRdData)
    );

    bareissEngine bareissEngine_i (
        .clk(clk), .rstN(rstN), .engineStart(engineStart), .engineDim(dimR),
        .ramRdAddr(ramRdAddr), .ramRdData(ramRdData),
        .ramWrEn(ramWrEn2), .ramWrAddr(ramWrAddr2), .ramWrData(ramWrData2),
        .engineDone(engineDone), .engineValue(engineValue), .engineStatus(engineStatus)
    );

endmodule

//--- verilog/bareissEngine.sv
// Fraction-free elimination sequencer; works in place on the matrix RAM and reports the determinant
module bareissEngine
    import detPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    engineStart,
    input  logic [DimW-1:0]         engineDim,
    output logic [RamAddrW-1:0]     ramRdAddr,
    input  logic signed [ElemW-1:0] ramRdData,
    output logic                    ramWrEn,
    output logic [RamAddrW-1:0]     ramWrAddr,
    output logic signed [ElemW-1:0] ramWrData,
    output logic                    engineDone,
    output logic signed [ElemW-1:0] engineValue,
    output detStatusT               engineStatus
);
    engineStateT             state;
    logic [DimW-1:0]         dimR;
    logic [DimW-1:0]         lastIdx;
    logic [DimW-1:0]         pivIdx;   // k
    logic [DimW-1:0]         rowIdx;   // i
    logic [DimW-1:0]         colIdx;   // j
    logic signed [ElemW-1:0] pivot;
    logic signed [ElemW-1:0] aij;
    logic signed [ElemW-1:0] aik;
    logic                    divStart;
    logic signed [ProdW-1:0] divNum;
    logic signed [ElemW-1:0] divDen;   // previous pivot, 1 before the first step
    logic signed [ElemW-1:0] divQuot;
    logic                    divDone;

    assign lastIdx = dimR - 1'b1;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state      <= engIdle;
            engineDone <= 1'b0;
            divStart   <= 1'b0;
            ramWrEn    <= 1'b0;
        end else begin
            engineDone <= 1'b0;
            divStart   <= 1'b0;
            ramWrEn    <= 1'b0;
            case (state)
                engIdle: if (engineStart) begin
                    dimR   <= engineDim;
                    pivIdx <= '0;
                    divDen <= ElemW'(1);
                    state  <= engPivotRd;
                end
                engPivotRd: begin
                    ramRdAddr <= cellAddr(pivIdx, pivIdx);
                    state     <= engPivotWait;
                end
                engPivotWait: state <= engPivotChk;  // RAM read latency
                engPivotChk: begin
                    if (pivIdx == lastIdx) begin
                        // bottom-right element is the determinant
                        engineValue  <= ramRdData;
                        engineStatus <= detOk;
                        engineDone   <= 1'b1;
                        state        <= engIdle;
                    end else if (ramRdData == '0) begin
                        engineValue  <= '0;  // no row swapping
                        engineStatus <= detPivotZero;
                        engineDone   <= 1'b1;
                        state        <= engIdle;
                    end else begin
                        pivot  <= ramRdData;
                        rowIdx <= pivIdx + 1'b1;
                        colIdx <= pivIdx + 1'b1;
                        state  <= engAddrAij;
                    end
                end
                engAddrAij: begin
                    ramRdAddr <= cellAddr(rowIdx, colIdx);
                    state     <= engAddrAik;
                end
                engAddrAik: begin
                    ramRdAddr <= cellAddr(rowIdx, pivIdx);
                    state     <= engAddrAkj;
                end
                engAddrAkj: begin
                    ramRdAddr <= cellAddr(pivIdx, colIdx);
                    aij       <= ramRdData;
                    state     <= engTakeAik;
                end
                engTakeAik: begin
                    aik   <= ramRdData;
                    state <= engTakeAkj;
                end
                engTakeAkj: begin
                    // a[k][j] is on the read port now
                    divNum   <= aij * pivot - aik * ramRdData;
                    divStart <= 1'b1;
                    state    <= engDivWait;
                end
                engDivWait: if (divDone) begin
                    ramWrEn   <= 1'b1;
                    ramWrAddr <= cellAddr(rowIdx, colIdx);
                    ramWrData <= divQuot;
                    state     <= engNext;
                end
                engNext: begin
                    if (colIdx != lastIdx) begin
                        colIdx <= colIdx + 1'b1;
                        state  <= engAddrAij;
                    end else if (rowIdx != lastIdx) begin
                        rowIdx <= rowIdx + 1'b1;
                        colIdx <= pivIdx + 1'b1;
                        state  <= engAddrAij;
                    end else begin
                        // trailing block done, this pivot divides the next step
                        divDen <= pivot;
                        pivIdx <= pivIdx + 1'b1;
                        state  <= engPivotRd;
                    end
                end
                default: state <= engIdle;
            endcase
        end
    end

    exactDivider exactDivider_i (
        .clk(clk),
        .rstN(rstN),
        .divStart(divStart),
        .divNum(divNum),
        .divDen(divDen),
        .divQuot(divQuot),
        .divDone(divDone)
    );

endmodule

//--- verilog/matrixLoader.sv
// Memory read master; fetches dim squared words and stores their signed low bytes in the matrix RAM
module matrixLoader
    import detPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    loadStart,
    input  logic [AddrW-1:0]        loadBase,
    input  logic [DimW-1:0]         loadDim,
    output logic [AddrW-1:0]        memAddress,
    output logic                    memRead,
    input  logic                    memWaitRequest,
    input  logic [DataW-1:0]        memReadData,
    input  logic                    memReadDataValid,
    output logic                    ramWrEn,
    output logic [RamAddrW-1:0]     ramWrAddr,
    output logic signed [ElemW-1:0] ramWrData,
    output logic                    loadDone
);
    loaderStateT     state;
    logic [DimW-1:0] dimR;
    logic [CntW-1:0] totalWords;
    logic [CntW-1:0] reqCount;   // accepted requests
    logic [CntW-1:0] rcvCount;   // returned words
    logic [DimW-1:0] rowIdx;
    logic [DimW-1:0] colIdx;
    logic            lastWord;

    assign lastWord = (rcvCount == totalWords - 1'b1);

    // request pipeline, one address per accepted read
    always_ff @(posedge clk) begin
        if (!rstN) begin
            memRead  <= 1'b0;
            reqCount <= '0;
        end else if (loadStart) begin
            memRead    <= 1'b1;
            memAddress <= loadBase;
            reqCount   <= '0;
        end else if (memRead && !memWaitRequest) begin
            memAddress <= memAddress + AddrW'(WordBytes);
            reqCount   <= reqCount + 1'b1;
            if (reqCount == totalWords - 1'b1) begin
                memRead <= 1'b0;  // last request taken
            end
        end
    end

    // receive pipeline, words arrive in request order
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= ldIdle;
            ramWrEn  <= 1'b0;
            loadDone <= 1'b0;
        end else begin
            ramWrEn  <= 1'b0;
            loadDone <= 1'b0;
            case (state)
                ldIdle: if (loadStart) begin
                    dimR       <= loadDim;
                    totalWords <= CntW'(loadDim) * CntW'(loadDim);
                    rcvCount   <= '0;
                    rowIdx     <= '0;
                    colIdx     <= '0;
                    state      <= ldBusy;
                end
                ldBusy: if (memReadDataValid) begin
                    ramWrEn   <= 1'b1;
                    ramWrAddr <= cellAddr(rowIdx, colIdx);
                    ramWrData <= {{(ElemW - EntryW){memReadData[EntryW-1]}},
                                  memReadData[EntryW-1:0]};
                    rcvCount  <= rcvCount + 1'b1;
                    if (colIdx == dimR - 1'b1) begin
                        colIdx <= '0;
                        rowIdx <= rowIdx + 1'b1;
                    end else begin
                        colIdx <= colIdx + 1'b1;
                    end
                    if (lastWord) state <= ldFlush;
                end
                ldFlush: begin
                    loadDone <= 1'b1;  // cycle after the final write
                    state    <= ldIdle;
                end
                default: state <= ldIdle;
            endcase
        end
    end

endmodule

//--- verilog/matrixRam.sv
// Matrix element store; one write port and one registered read port, rows at a fixed stride
module matrixRam
    import detPkg::*;
(
    input  logic                    clk,
    input  logic                    wrEn,
    input  logic [RamAddrW-1:0]     wrAddr,
    input  logic signed [ElemW-1:0] wrData,
    input  logic [RamAddrW-1:0]     rdAddr,
    output logic signed [ElemW-1:0] rdData
);
    logic signed [ElemW-1:0] mem [RamDepth];

    // row i lives at i * MaxDim, unused columns stay untouched

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];  // one cycle read latency
    end

endmodule

//--- verilog/exactDivider.sv
// Sequential signed divider for the exact elimination divisions; fixed latency of ProdW plus 1 cycles
module exactDivider
    import detPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    divStart,
    input  logic signed [ProdW-1:0] divNum,
    input  logic signed [ElemW-1:0] divDen,
    output logic signed [ElemW-1:0] divQuot,
    output logic                    divDone
);
    logic [ProdW-1:0]   quotR;     // numerator bits shift out, quotient bits shift in
    logic [ElemW-1:0]   remR;
    logic [ElemW-1:0]   denMag;
    logic               negR;
    logic [DivCntW-1:0] bitsLeft;
    logic [ElemW:0]     shifted;
    logic [ElemW+1:0]   trial;
    logic               fits;
    logic [ElemW-1:0]   remNext;
    logic [ProdW-1:0]   quotNext;
    logic [ElemW-1:0]   quotMag;

    // one restoring step per cycle
    always_comb begin
        shifted  = {remR, quotR[ProdW-1]};
        trial    = {1'b0, shifted} - {2'b00, denMag};
        fits     = !trial[ElemW+1];
        remNext  = fits ? trial[ElemW-1:0] : shifted[ElemW-1:0];
        quotNext = {quotR[ProdW-2:0], fits};
        quotMag  = quotNext[ElemW-1:0];  // exact quotient fits an element
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            bitsLeft <= '0;
            divDone  <= 1'b0;
        end else begin
            divDone <= 1'b0;
            if (divStart) begin
                quotR    <= divNum[ProdW-1] ? -divNum : divNum;
                remR     <= '0;
                denMag   <= divDen[ElemW-1] ? -divDen : divDen;
                negR     <= divNum[ProdW-1] ^ divDen[ElemW-1];
                bitsLeft <= DivCntW'(ProdW);
            end else if (bitsLeft != '0) begin
                quotR    <= quotNext;
                remR     <= remNext;
                bitsLeft <= bitsLeft - 1'b1;
                if (bitsLeft == DivCntW'(1)) begin
                    divQuot <= negR ? -quotMag : quotMag;  // sign fix-up
                    divDone <= 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/detPkg.sv
// Shared widths, limits, state types and RAM addressing for the determinant unit; imported by each RTL module
package detPkg;

    localparam int MaxDim    = 4;    // largest matrix side
    localparam int MinDim    = 2;
    localparam int DimW      = 3;    // dimension or row/column index
    localparam int AddrW     = 24;   // memory byte address
    localparam int DataW     = 32;
    localparam int EntryW    = 8;    // signed low byte of each memory word
    localparam int ElemW     = 64;   // stored element and determinant
    localparam int ProdW     = 128;  // cross-product numerator
    localparam int RamAddrW  = 4;
    localparam int RamDepth  = 16;
    localparam int WordBytes = 4;
    localparam int CntW      = $clog2(RamDepth + 1);  // word counters up to dim squared
    localparam int DivCntW   = $clog2(ProdW + 1);     // divider bit counter

    typedef enum logic [1:0] {detOk, detPivotZero, detBadDim} detStatusT;

    typedef enum logic [1:0] {ldIdle, ldBusy, ldFlush} loaderStateT;

    typedef enum logic [3:0] {
        engIdle, engPivotRd, engPivotWait, engPivotChk,
        engAddrAij, engAddrAik, engAddrAkj, engTakeAik, engTakeAkj,
        engDivWait, engNext
    } engineStateT;

    typedef enum logic [1:0] {topIdle, topLoading, topComputing, topReporting} topStateT;

    // row r starts at r * MaxDim whatever the active dimension
    function automatic logic [RamAddrW-1:0] cellAddr(
        input logic [DimW-1:0] row,
        input logic [DimW-1:0] col
    );
        return RamAddrW'(row * MaxDim + col);
    endfunction

endpackage
